//--- design/branch_pkg.sv
package branch_pkg;

    typedef logic [31:0] data_t;                  // Data and address word

    localparam int BHT_INDEX_MAX = 16;            // Widest table index a packet carries
    typedef logic [BHT_INDEX_MAX-1:0] bht_index_t;

    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // Branch condition codes
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    typedef struct packed {
        logic       imm12;                        // Sign bit of offset
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;                        // Sits where rd would be
        logic [6:0] opcode;
    } b_inst_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_inst_t;

    // Same instruction word, two field layouts
    typedef union packed {
        b_inst_t     b;                           // Immediate decode
        r_inst_t     r;                           // Generic opcode and funct3 decode
        logic [31:0] raw;
    } inst_t;

    typedef struct packed {
        data_t pc;
        inst_t inst;
        data_t rs1_value;
        data_t rs2_value;
        logic  pred_taken;                        // Filled in by top level
    } issue_t;

    typedef struct packed {
        data_t      target;
        data_t      pc;
        logic       take;                         // Real outcome
        logic       pred_taken;
        bht_index_t bht_index;                    // Entry to train
    } fu_packet_t;

    typedef enum logic [1:0] {
        NOTHING,
        CLEAR,                                    // Prediction was right
        SQUASH                                    // Flush younger work
    } br_task_t;

    typedef struct packed {
        logic  valid;
        data_t pc;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        bht_index_t index;
        logic       taken;
    } bht_update_t;

endpackage

//--- design/branch_predictor.sv
module branch_predictor #(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  branch_pkg::data_t             lookup_pc,
    input  branch_pkg::bht_update_t       update,
    output logic                          pred_taken,
    output logic [BHT_INDEX_BITS-1:0]     bht_index
);
    localparam int ENTRIES = 2 ** BHT_INDEX_BITS;

    // 2-bit saturating counter encoding
    localparam logic [1:0] STRONG_NT = 2'b00;
    localparam logic [1:0] WEAK_NT   = 2'b01;
    localparam logic [1:0] STRONG_T  = 2'b11;

    logic [1:0]                counters [ENTRIES];
    logic [BHT_INDEX_BITS-1:0] upd_index;
    logic [1:0]                upd_entry;
    logic [1:0]                upd_next;
    logic                      upd_enable;

    // Word aligned PCs, so skip the low two bits
    assign bht_index  = lookup_pc[BHT_INDEX_BITS+1:2];
    assign pred_taken = counters[bht_index][1];       // Upper bit set means taken

    assign upd_index  = update.index[BHT_INDEX_BITS-1:0];
    assign upd_entry  = counters[upd_index];
    assign upd_enable = update.valid && !stall;       // Frozen with the rest of the unit

    always_comb begin
        upd_next = upd_entry;
        if (update.taken) begin
            if (upd_entry != STRONG_T) begin
                upd_next = upd_entry + 2'd1;          // Count toward taken
            end
        end else begin
            if (upd_entry != STRONG_NT) begin
                upd_next = upd_entry - 2'd1;          // Count toward not taken
            end
        end
    end

    // Lookup in the same cycle as a write still sees the old value
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= WEAK_NT;
            end
        end else if (upd_enable) begin
            counters[upd_index] <= upd_next;
        end
    end

endmodule

//--- design/branch_target_gen.sv
module branch_target_gen (
    input  branch_pkg::inst_t inst,
    input  branch_pkg::data_t pc,
    output branch_pkg::data_t target
);
    branch_pkg::b_inst_t b;
    branch_pkg::data_t   imm;

    assign b = inst.b;                            // Read the word through the B layout

    // B-type offset is scattered over the word, bit 0 always zero
    assign imm = {
        {19{b.imm12}},                            // Sign extension
        b.imm12,
        b.imm11,
        b.imm10_5,
        b.imm4_1,
        1'b0
    };

    assign target = pc + imm;

endmodule

//--- design/conditional_branch.sv
module conditional_branch #(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        stall,
    input  logic                        rd_in,
    input  branch_pkg::issue_t          is_pack,
    input  logic [BHT_INDEX_BITS-1:0]   bht_index,
    output branch_pkg::fu_packet_t      fu_pack,
    output branch_pkg::br_task_t        br_task,
    output logic                        data_ready
);
    branch_pkg::r_inst_t r;
    branch_pkg::data_t   target;
    logic                is_branch;
    logic                cond;
    logic                take;
    logic                accept;

    assign r         = is_pack.inst.r;                // Generic view for decode
    assign is_branch = r.opcode == branch_pkg::OPCODE_BRANCH;
    assign accept    = rd_in && !stall;

    always_comb begin
        case (r.funct3)
            branch_pkg::FUNCT3_BEQ:  cond = $signed(is_pack.rs1_value) == $signed(is_pack.rs2_value);
            branch_pkg::FUNCT3_BNE:  cond = $signed(is_pack.rs1_value) != $signed(is_pack.rs2_value);
            branch_pkg::FUNCT3_BLT:  cond = $signed(is_pack.rs1_value) <  $signed(is_pack.rs2_value);
            branch_pkg::FUNCT3_BGE:  cond = $signed(is_pack.rs1_value) >= $signed(is_pack.rs2_value);
            branch_pkg::FUNCT3_BLTU: cond = is_pack.rs1_value <  is_pack.rs2_value;
            branch_pkg::FUNCT3_BGEU: cond = is_pack.rs1_value >= is_pack.rs2_value;
            default:                 cond = 1'b0;     // Codes 010 and 011 never branch
        endcase
    end

    assign take = is_branch && cond;

    branch_target_gen u_target_gen (
        .inst   (is_pack.inst),
        .pc     (is_pack.pc),
        .target (target)
    );

    // Control part of the result
    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready <= 1'b0;
            br_task    <= branch_pkg::NOTHING;
        end else if (!stall) begin
            if (rd_in) begin
                data_ready <= 1'b1;
                br_task    <= (take == is_pack.pred_taken) ? branch_pkg::CLEAR
                                                           : branch_pkg::SQUASH;
            end else begin
                data_ready <= 1'b0;                   // Idle cycle empties the slot
                br_task    <= branch_pkg::NOTHING;
            end
        end
    end

    // Payload only loads on an accepted issue
    always_ff @(posedge clock) begin
        if (accept) begin
            fu_pack.target     <= target;
            fu_pack.pc         <= is_pack.pc;
            fu_pack.take       <= take;
            fu_pack.pred_taken <= is_pack.pred_taken;
            fu_pack.bht_index  <= branch_pkg::bht_index_t'(bht_index);
        end
    end

endmodule

//--- design/branch_recovery.sv
module branch_recovery #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int COUNT_WIDTH    = 16
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        stall,
    input  branch_pkg::fu_packet_t      fu_pack,
    input  branch_pkg::br_task_t        br_task,
    input  logic                        data_ready,
    output branch_pkg::redirect_t       redirect,
    output branch_pkg::bht_update_t     bht_update,
    output logic [COUNT_WIDTH-1:0]      branch_count,
    output logic [COUNT_WIDTH-1:0]      mispredict_count
);
    logic                      squash;
    logic [BHT_INDEX_BITS-1:0] index;

    assign squash = data_ready && (br_task == branch_pkg::SQUASH);
    assign index  = fu_pack.bht_index[BHT_INDEX_BITS-1:0];  // Only the live index bits

    // Redirect fetch in the same cycle the result shows up
    always_comb begin
        redirect.valid = squash;
        if (fu_pack.take) begin
            redirect.pc = fu_pack.target;
        end else begin
            redirect.pc = fu_pack.pc + 32'd4;             // Fall through
        end
    end

    // Predictor drops the write itself while stalled
    always_comb begin
        bht_update.valid = data_ready;
        bht_update.index = branch_pkg::bht_index_t'(index);
        bht_update.taken = fu_pack.take;
    end

    // Stalled result is only counted when it finally leaves
    always_ff @(posedge clock) begin
        if (reset) begin
            branch_count     <= '0;
            mispredict_count <= '0;
        end else if (!stall && data_ready) begin
            branch_count <= branch_count + 1'b1;          // Wraps
            if (squash) begin
                mispredict_count <= mispredict_count + 1'b1;
            end
        end
    end

endmodule

//--- design/branch_unit_top.sv
module branch_unit_top #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int COUNT_WIDTH    = 16
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        issue_valid,
    input  logic                        stall,
    input  branch_pkg::issue_t          issue,
    output branch_pkg::fu_packet_t      result,
    output branch_pkg::br_task_t        br_task,
    output logic                        data_ready,
    output branch_pkg::redirect_t       redirect,
    output logic [COUNT_WIDTH-1:0]      branch_count,
    output logic [COUNT_WIDTH-1:0]      mispredict_count
);
    logic                      pred_taken;
    logic [BHT_INDEX_BITS-1:0] bht_index;
    branch_pkg::issue_t        is_pack;
    branch_pkg::bht_update_t   bht_update;

    // Incoming pred_taken is ignored, the table decides
    always_comb begin
        is_pack            = issue;
        is_pack.pred_taken = pred_taken;
    end

    branch_predictor #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_predictor (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .lookup_pc  (issue.pc),
        .update     (bht_update),
        .pred_taken (pred_taken),
        .bht_index  (bht_index)
    );

    conditional_branch #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_branch (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .rd_in      (issue_valid),
        .is_pack    (is_pack),
        .bht_index  (bht_index),
        .fu_pack    (result),
        .br_task    (br_task),
        .data_ready (data_ready)
    );

    branch_recovery #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .COUNT_WIDTH    (COUNT_WIDTH)
    ) u_recovery (
        .clock            (clock),
        .reset            (reset),
        .stall            (stall),
        .fu_pack          (result),
        .br_task          (br_task),
        .data_ready       (data_ready),
        .redirect         (redirect),
        .bht_update       (bht_update),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

endmodule

//--- test/branch_unit_tb.sv
module branch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_BITS   = 6;
    localparam int ENTRIES      = 2 ** INDEX_BITS;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 3000;
    localparam int WAIT_LIMIT   = 20;
    localparam logic [31:0] SEED = 32'd66102;

    logic                   clock;
    logic                   reset;
    logic                   issue_valid;
    logic                   stall;
    branch_pkg::issue_t     issue;
    branch_pkg::fu_packet_t result;
    branch_pkg::br_task_t   br_task;
    logic                   data_ready;
    branch_pkg::redirect_t  redirect;
    logic [15:0]            branch_count;
    logic [15:0]            mispredict_count;

    logic [31:0] lfsr;
    logic [31:0] offset;                             // Sign-extended B offset of current issue
    int          stall_left;
    int          errors;
    int          timeouts;
    int          squash_hits;
    int          stall_hits;
    int          illegal_hits;
    int          negative_hits;

    // Reference model state
    logic [1:0]             model_table [ENTRIES];
    logic                   exp_ready;
    branch_pkg::br_task_t   exp_task;
    logic [31:0]            exp_pc;
    logic [31:0]            exp_target;
    logic                   exp_take;
    logic                   exp_pred;
    logic [INDEX_BITS-1:0]  exp_index;
    logic [15:0]            exp_branches;
    logic [15:0]            exp_misses;
    logic [31:0]            exp_redirect_pc;
    logic [INDEX_BITS-1:0]  look_index;
    logic                   look_pred;
    logic                   look_take;

    // Snapshot of the outputs at each edge, for the stall checks
    logic                   model_reset;
    logic                   stalled_edge;
    logic                   held_ready;
    branch_pkg::br_task_t   held_task;
    branch_pkg::fu_packet_t held_result;
    logic [31:0]            held_counts;

    branch_unit_top DUT (
        .clock            (clock),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .stall            (stall),
        .issue            (issue),
        .result           (result),
        .br_task          (br_task),
        .data_ready       (data_ready),
        .redirect         (redirect),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    always #20 clock = ~clock;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic feedback;
        feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // Small PC set so table entries get reused, 0x1000 and 0x1100 share an entry
    function automatic logic [31:0] pick_pc(logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_1000;
            3'd1:    return 32'h0000_1004;
            3'd2:    return 32'h0000_1010;
            3'd3:    return 32'h0000_1100;
            3'd4:    return 32'h8000_0ffc;
            3'd5:    return 32'h0000_203c;
            3'd6:    return 32'h7fff_fff0;
            default: return 32'h0000_1008;
        endcase
    endfunction

    // Signed order is unsigned order with the sign bits flipped
    function automatic logic branch_taken(logic [2:0] funct3, logic [31:0] a, logic [31:0] b);
        logic equal;
        logic less_signed;
        logic less_unsigned;
        equal         = (a == b);
        less_signed   = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        less_unsigned = a < b;
        case (funct3)
            3'b000:  return equal;                   // BEQ
            3'b001:  return !equal;                  // BNE
            3'b100:  return less_signed;             // BLT
            3'b101:  return !less_signed;            // BGE
            3'b110:  return less_unsigned;           // BLTU
            3'b111:  return !less_unsigned;          // BGEU
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [1:0] counter_next(logic [1:0] count, logic taken);
        if (taken) begin
            return (count == 2'd3) ? 2'd3 : count + 2'd1;
        end
        return (count == 2'd0) ? 2'd0 : count - 2'd1;
    endfunction

    function automatic void show_mismatch(string name, logic [95:0] expected,
                                          logic [95:0] actual);
        errors++;
        $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    endfunction

    task automatic drive_random_cycle();
        logic [12:0] imm;
        logic [2:0]  funct3;
        logic [1:0]  mode;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] a;
        logic [31:0] b;
        if (stall_left > 0) begin
            stall = 1'b1;
            stall_left--;
        end else if (random_bits(4) == 0) begin
            stall      = 1'b1;                       // Start a burst of one to four cycles
            stall_left = int'(random_bits(2));
        end else begin
            stall = 1'b0;
        end
        issue_valid = (random_bits(2) != 0);
        funct3      = 3'(random_bits(3));            // Includes 010 and 011
        mode        = 2'(random_bits(2));
        rs1         = 5'(random_bits(5));
        rs2         = 5'(random_bits(5));
        imm         = {12'(random_bits(12)), 1'b0};
        a           = random_bits(32);
        case (mode)
            2'd0:    b = a;                          // Equal operands
            2'd1:    b = {~a[31], 31'(random_bits(31))};  // Opposite sign
            default: b = random_bits(32);
        endcase
        issue.pc         = pick_pc(3'(random_bits(3)));
        issue.inst.raw   = {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
        issue.rs1_value  = a;
        issue.rs2_value  = b;
        issue.pred_taken = lfsr_step();              // DUT must ignore this
        offset           = {{19{imm[12]}}, imm};
    endtask

    assign look_index      = issue.pc[INDEX_BITS+1:2];
    assign look_pred       = model_table[look_index][1];
    assign look_take       = branch_taken(issue.inst.raw[14:12], issue.rs1_value,
                                          issue.rs2_value);
    assign exp_redirect_pc = exp_take ? exp_target : exp_pc + 32'd4;

    // Model advances on the same edges as the unit
    always @(posedge clock) begin
        model_reset  <= reset;
        stalled_edge <= stall && !reset;
        held_ready   <= data_ready;
        held_task    <= br_task;
        held_result  <= result;
        held_counts  <= {branch_count, mispredict_count};
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                model_table[i] <= 2'b01;             // Weakly not taken
            end
            exp_ready    <= 1'b0;
            exp_task     <= branch_pkg::NOTHING;
            exp_branches <= '0;
            exp_misses   <= '0;
        end else if (!stall) begin
            if (exp_ready) begin
                model_table[exp_index] <= counter_next(model_table[exp_index], exp_take);
                exp_branches           <= exp_branches + 16'd1;
                if (exp_task == branch_pkg::SQUASH) begin
                    exp_misses <= exp_misses + 16'd1;
                end
            end
            if (issue_valid) begin
                exp_ready  <= 1'b1;
                exp_task   <= (look_take == look_pred) ? branch_pkg::CLEAR : branch_pkg::SQUASH;
                exp_pc     <= issue.pc;
                exp_target <= issue.pc + offset;
                exp_take   <= look_take;
                exp_pred   <= look_pred;
                exp_index  <= look_index;
                if (look_take != look_pred) begin
                    squash_hits <= squash_hits + 1;
                end
                if (issue.inst.raw[14:13] == 2'b01) begin
                    illegal_hits <= illegal_hits + 1;
                end
                if (offset[31]) begin
                    negative_hits <= negative_hits + 1;
                end
            end else begin
                exp_ready <= 1'b0;
                exp_task  <= branch_pkg::NOTHING;
            end
        end else if (data_ready) begin
            stall_hits <= stall_hits + 1;
        end
    end

    // Checks run on the falling edge where every output is settled
    reset_ctrl_check: assert property (@(negedge clock)
        model_reset |-> {data_ready, br_task, redirect.valid} == 4'b0)
        else show_mismatch("reset_ctrl_check", 0, {data_ready, br_task, redirect.valid});
    reset_count_check: assert property (@(negedge clock)
        model_reset |-> {branch_count, mispredict_count} == 32'd0)
        else show_mismatch("reset_count_check", 0, {branch_count, mispredict_count});
    ready_check: assert property (@(negedge clock) data_ready == exp_ready)
        else show_mismatch("ready_check", exp_ready, data_ready);
    task_check: assert property (@(negedge clock) br_task == exp_task)
        else show_mismatch("task_check", exp_task, br_task);
    take_check: assert property (@(negedge clock) exp_ready |-> result.take == exp_take)
        else show_mismatch("take_check", exp_take, result.take);
    target_check: assert property (@(negedge clock) exp_ready |-> result.target == exp_target)
        else show_mismatch("target_check", exp_target, result.target);
    pc_check: assert property (@(negedge clock) exp_ready |-> result.pc == exp_pc)
        else show_mismatch("pc_check", exp_pc, result.pc);
    pred_check: assert property (@(negedge clock) exp_ready |-> result.pred_taken == exp_pred)
        else show_mismatch("pred_check", exp_pred, result.pred_taken);
    index_check: assert property (@(negedge clock)
        exp_ready |-> result.bht_index == 16'(exp_index))
        else show_mismatch("index_check", exp_index, result.bht_index);
    redirect_valid_check: assert property (@(negedge clock)
        redirect.valid == (exp_ready && exp_task == branch_pkg::SQUASH))
        else show_mismatch("redirect_valid_check", exp_ready && exp_task == branch_pkg::SQUASH,
                           redirect.valid);
    redirect_pc_check: assert property (@(negedge clock)
        redirect.valid |-> redirect.pc == exp_redirect_pc)
        else show_mismatch("redirect_pc_check", exp_redirect_pc, redirect.pc);
    branch_count_check: assert property (@(negedge clock) branch_count == exp_branches)
        else show_mismatch("branch_count_check", exp_branches, branch_count);
    mispredict_count_check: assert property (@(negedge clock) mispredict_count == exp_misses)
        else show_mismatch("mispredict_count_check", exp_misses, mispredict_count);
    stall_ctrl_check: assert property (@(negedge clock)
        stalled_edge |-> {data_ready, br_task} == {held_ready, held_task})
        else show_mismatch("stall_ctrl_check", {held_ready, held_task}, {data_ready, br_task});
    stall_count_check: assert property (@(negedge clock)
        stalled_edge |-> {branch_count, mispredict_count} == held_counts)
        else show_mismatch("stall_count_check", held_counts, {branch_count, mispredict_count});
    stall_result_check: assert property (@(negedge clock)
        stalled_edge && held_ready |-> result == held_result)
        else show_mismatch("stall_result_check", held_result, result);

    initial begin
        int waited;
        clock         = 1'b0;
        reset         = 1'b1;
        issue_valid   = 1'b0;
        stall         = 1'b0;
        issue         = '0;
        offset        = '0;
        lfsr          = SEED;
        stall_left    = 0;
        errors        = 0;
        timeouts      = 0;
        squash_hits   = 0;
        stall_hits    = 0;
        illegal_hits  = 0;
        negative_hits = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clock);
        end
        reset = 1'b0;

        waited = 0;
        while ((data_ready || br_task != branch_pkg::NOTHING) && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (data_ready || br_task != branch_pkg::NOTHING) begin
            $display("Timeout: the unit did not settle to idle after reset");
            timeouts++;
        end

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_random_cycle();
            @(negedge clock);
        end

        issue_valid = 1'b0;                          // Let the last result retire
        stall       = 1'b0;
        waited      = 0;
        while (data_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (data_ready) begin
            $display("Timeout: the last result never left the result register");
            timeouts++;
        end

        if (squash_hits == 0 || stall_hits == 0 || illegal_hits == 0 || negative_hits == 0) begin
            $display("Stimulus missed a squash, stall, illegal code or negative offset case");
            errors++;
        end

        $display("Check failures: %0d, timeouts: %0d (branches %0d, mispredicts %0d)",
                 errors, timeouts, branch_count, mispredict_count);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim.f
design/branch_pkg.sv
design/branch_predictor.sv
design/branch_target_gen.sv
design/conditional_branch.sv
design/branch_recovery.sv
design/branch_unit_top.sv
test/branch_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build the branch unit testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module branch_unit_tb \
    -f sim.f -o branch_unit_sim &&
    ./obj_dir/branch_unit_sim > sim.log 2>&1
grep -q "Testbench passed" sim.log 2>/dev/null && echo "Simulation OK" ||
    { echo "Simulation FAILED, see sim.log"; exit 1; }
